/* bench/fetch_mem_sva.sv */
module fetch_mem_sva (
  input logic                  clock,
  input logic                  reset,
  input fetch_pkg::mem_req_t   data_req,
  input fetch_pkg::mem_req_t   icache_req,
  input fetch_pkg::mem_tag_t   icache_response,
  input fetch_pkg::mem_req_t   mem_req,
  input fetch_pkg::mem_tag_t   icache_tag,
  input fetch_pkg::mem_tag_t   data_tag
);

  import fetch_pkg::*;

  // Bus stays quiet while reset is held
  a_idle_in_reset: assert property (@(posedge clock) reset |-> (mem_req.command == BUS_NONE))
    else $error("bus request issued during reset");

  a_retry_same: assert property (@(posedge clock)
    (!reset && (data_req.command == BUS_NONE) && (icache_req.command == BUS_LOAD) &&
     (icache_response == '0))
    |=> ((data_req.command != BUS_NONE) || (icache_req == $past(icache_req))))
    else $error("refused instruction request changed before acceptance");

  a_one_owner: assert property (@(posedge clock) disable iff (reset)
    !((icache_tag != '0) && (data_tag != '0)))
    else $error("returning tag routed to both sides");

endmodule

bind fetch_mem_top fetch_mem_sva i_sva (
  .clock           (clock),
  .reset           (reset),
  .data_req        (data_req),
  .icache_req      (icache_req),
  .icache_response (icache_response),
  .mem_req         (mem_req),
  .icache_tag      (icache_tag),
  .data_tag        (data_tag)
);

/* bench/fetch_mem_tb.sv */
module fetch_mem_tb;

  import fetch_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int ROW_LIMIT    = 40;   // Cycles allowed per row
  localparam int DRAIN_LIMIT  = 20;
  localparam int NUM_ROWS     = 10;
  localparam logic [63:0] MEM_KEY = 64'h5a5a_c3c3_0f0f_9696;

  typedef struct packed {
    logic [63:0]  fetch;
    logic         hit;     // Line already filled by an earlier row
    bus_command_e cmd;
    logic [63:0]  daddr;
    logic [63:0]  word;
  } row_t;

  typedef struct {
    mem_tag_t    tag;
    logic [63:0] addr;
    int          due;
  } pend_t;

  logic         clock;
  logic         reset;
  icache_addr_u fetch_addr;
  mem_req_t     data_req;
  mem_reply_t   mem_reply;
  logic [63:0]  inst_data;
  logic         inst_valid;
  mem_req_t     mem_req;
  mem_tag_t     data_response;
  mem_tag_t     data_tag;
  logic [63:0]  data_rdata;

  row_t     rows [NUM_ROWS];
  pend_t    pending[$];    // Loads accepted by the memory model
  pend_t    data_exp[$];   // Data port loads awaiting return
  int       cycle;
  mem_tag_t next_tag;

  fetch_mem_top i_dut (
    .clock         (clock),
    .reset         (reset),
    .fetch_addr    (fetch_addr),
    .data_req      (data_req),
    .mem_reply     (mem_reply),
    .inst_data     (inst_data),
    .inst_valid    (inst_valid),
    .mem_req       (mem_req),
    .data_response (data_response),
    .data_tag      (data_tag),
    .data_rdata    (data_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial cycle = 0;
  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [63:0] mem_word(logic [63:0] addr);
    return addr ^ MEM_KEY;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cmd(string name, bus_command_e got, bus_command_e exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_req(string name, mem_req_t got, mem_req_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_data(logic [63:0] got_d, mem_tag_t got_t,
                            logic [63:0] exp_d, mem_tag_t exp_t);
    if ((got_d !== exp_d) || (got_t !== exp_t)) begin
      fail_run($sformatf("error: data_tag/data_rdata got %h/%h expected %h/%h",
                         got_t, got_d, exp_t, exp_d));
    end
  endtask

  // Next free tag in rotation, skipping any still in flight
  function automatic mem_tag_t take_tag();
    mem_tag_t cand;
    logic     busy;
    for (int n = 0; n < 15; n++) begin
      cand     = next_tag;
      next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
      busy     = (cand == mem_reply.tag);
      foreach (pending[k]) begin
        if (pending[k].tag == cand) busy = 1'b1;
      end
      if (!busy) return cand;
    end
    return '0;   // All tags busy, refuse
  endfunction

  task automatic set_row(int i, logic [63:0] fetch, logic hit,
                         bus_command_e cmd, logic [63:0] daddr);
    rows[i].fetch = fetch;
    rows[i].hit   = hit;
    rows[i].cmd   = cmd;
    rows[i].daddr = daddr;
    rows[i].word  = mem_word({fetch[63:3], 3'b000});
  endtask

  task automatic load_table();
    set_row(0, 64'h1000, 1'b0, BUS_NONE,  64'h0);
    set_row(1, 64'h1008, 1'b0, BUS_NONE,  64'h0);
    set_row(2, 64'h1004, 1'b1, BUS_NONE,  64'h0);
    set_row(3, 64'h2000, 1'b0, BUS_NONE,  64'h0);    // Evicts 0x1000
    set_row(4, 64'h1000, 1'b0, BUS_NONE,  64'h0);
    set_row(5, 64'h1010, 1'b0, BUS_LOAD,  64'h8000);
    set_row(6, 64'h1008, 1'b1, BUS_STORE, 64'h9000);
    set_row(7, 64'h2008, 1'b0, BUS_LOAD,  64'ha000);
    set_row(8, 64'h1018, 1'b0, BUS_NONE,  64'h0);
    set_row(9, 64'h1010, 1'b1, BUS_NONE,  64'h0);
  endtask

  // Memory model
  initial begin
    pend_t    p;
    logic     prev_refused;
    mem_req_t prev_req;
    int       k;
    void'($urandom(42));
    mem_reply    = '0;
    next_tag     = 4'h1;
    prev_refused = 1'b0;
    prev_req     = '0;
    forever begin
      @(posedge clock);
      #2;
      mem_reply = '0;
      if (!reset) begin
        for (k = 0; k < pending.size(); k++) begin
          if (pending[k].due <= cycle) begin
            mem_reply.tag  = pending[k].tag;
            mem_reply.data = mem_word(pending[k].addr);
            pending.delete(k);
            break;
          end
        end
        if ((mem_req.command != BUS_NONE) && (($urandom % 4) != 0)) begin
          mem_reply.response = take_tag();
        end
      end
      @(negedge clock);
      if (!reset && (mem_req.command == BUS_LOAD) && (mem_reply.response != '0)) begin
        p.tag  = mem_reply.response;
        p.addr = mem_req.addr;
        p.due  = cycle + 2 + ($urandom % 5);
        pending.push_back(p);
      end
      if (data_tag != '0) begin
        k = -1;
        foreach (data_exp[j]) begin
          if ((k < 0) && (data_exp[j].tag == data_tag)) k = j;
        end
        if (k < 0) fail_run("data tag returned with no data load outstanding");
        check_data(data_rdata, data_tag, mem_word(data_exp[k].addr), data_exp[k].tag);
        data_exp.delete(k);
      end
      if (prev_refused && (data_req.command == BUS_NONE)) begin
        check_req("mem_req retry", mem_req, prev_req);
      end
      prev_refused = !reset && (data_req.command == BUS_NONE) &&
                     (mem_req.command == BUS_LOAD) && (mem_reply.response == '0);
      prev_req     = mem_req;
    end
  end

  // Caller has already moved to just after a rising edge
  task automatic apply_row(int i);
    mem_req_t dexp;
    mem_req_t iexp;
    pend_t    d;
    logic     data_busy;
    int       n;
    fetch_addr.raw = rows[i].fetch;
    dexp           = '0;
    if (rows[i].cmd != BUS_NONE) begin
      dexp.command = rows[i].cmd;
      dexp.addr    = rows[i].daddr;
      dexp.data    = ~rows[i].daddr;
    end
    data_req     = dexp;
    data_busy    = (rows[i].cmd != BUS_NONE);
    iexp.command = BUS_LOAD;
    iexp.addr    = {rows[i].fetch[63:3], 3'b000};
    iexp.data    = '0;
    n            = 0;
    @(negedge clock);
    if (!data_busy && rows[i].hit && (mem_req.command != BUS_NONE)) begin
      fail_run($sformatf("row %0d issued a bus request on a cache hit", i));
    end
    if (!data_busy && !rows[i].hit) check_req("mem_req", mem_req, iexp);
    if (rows[i].hit && !inst_valid) fail_run($sformatf("row %0d missed a filled line", i));
    if (!rows[i].hit && inst_valid) fail_run($sformatf("row %0d hit an unfilled line", i));
    while (1) begin
      if (data_busy) begin
        check_req("mem_req", mem_req, dexp);
        if (data_response != '0) begin
          if (rows[i].cmd == BUS_LOAD) begin
            d.tag  = data_response;
            d.addr = rows[i].daddr;
            d.due  = 0;
            data_exp.push_back(d);
          end
          data_busy = 1'b0;
        end
      end
      if (inst_valid) check_word("inst_data", inst_data, rows[i].word);
      if (inst_valid && !data_busy) break;
      n++;
      if (n > ROW_LIMIT) fail_run($sformatf("row %0d did not finish in time", i));
      @(posedge clock);
      #1;
      if (!data_busy) data_req = '0;
      @(negedge clock);
    end
  endtask

  initial begin
    int n;
    reset          = 1'b1;
    fetch_addr.raw = '0;
    data_req       = '0;
    load_table();
    repeat (RESET_CYCLES - 1) @(posedge clock);
    @(negedge clock);
    check_cmd("mem_req.command", mem_req.command, BUS_NONE);   // Idle bus in reset
    if (inst_valid) fail_run("inst_valid high while reset is held");
    @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
      @(posedge clock);
      #1;
    end
    data_req = '0;
    n = 0;
    while ((data_exp.size() > 0) && (n < DRAIN_LIMIT)) begin
      @(negedge clock);
      n++;
    end
    if (data_exp.size() > 0) begin
      fail_run("data loads still outstanding at end of test");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #((RESET_CYCLES + NUM_ROWS * ROW_LIMIT + DRAIN_LIMIT) * 40);
    fail_run("timeout: test did not complete");
  end

endmodule

/* fetch_mem_top.f */
+incdir+source
source/fetch_pkg.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/mem_bus_arbiter.sv
source/fetch_mem_top.sv
bench/fetch_mem_sva.sv
bench/fetch_mem_tb.sv

/* source/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Bus word and address width
`define XLEN 64

// Direct-mapped instruction cache, one 64-bit word per line
`define ICACHE_IDX_BITS 5
`define ICACHE_LINES 32
`define ICACHE_TAG_BITS 8
`define LINE_OFFSET_BITS 3

// Memory transaction tags, value 0 means none
`define MEM_TAG_BITS 4
`define NUM_MEM_TAGS 16

`endif

/* source/fetch_mem_top.sv */
`include "fetch_defines.svh"

module fetch_mem_top (
  input  logic                    clock,
  input  logic                    reset,
  input  fetch_pkg::icache_addr_u fetch_addr,
  input  fetch_pkg::mem_req_t     data_req,
  input  fetch_pkg::mem_reply_t   mem_reply,
  output logic [`XLEN-1:0]        inst_data,
  output logic                    inst_valid,
  output fetch_pkg::mem_req_t     mem_req,
  output fetch_pkg::mem_tag_t     data_response,
  output fetch_pkg::mem_tag_t     data_tag,
  output logic [`XLEN-1:0]        data_rdata
);

  import fetch_pkg::*;

  logic [`ICACHE_IDX_BITS-1:0] rd_idx;
  logic [`ICACHE_TAG_BITS-1:0] rd_tag;
  logic                        rd_hit;
  icache_fill_t                fill;
  mem_req_t                    icache_req;
  mem_tag_t                    icache_response;
  mem_tag_t                    icache_tag;

  icache_ctrl i_icache_ctrl (
    .clock           (clock),
    .reset           (reset),
    .fetch_addr      (fetch_addr),
    .rd_hit          (rd_hit),
    .icache_response (icache_response),
    .icache_tag      (icache_tag),
    .rd_idx          (rd_idx),
    .rd_tag          (rd_tag),
    .fill            (fill),
    .icache_req      (icache_req),
    .inst_valid      (inst_valid)
  );

  icache_mem i_icache_mem (
    .clock     (clock),
    .reset     (reset),
    .rd_idx    (rd_idx),
    .rd_tag    (rd_tag),
    .fill      (fill),
    .fill_data (mem_reply.data),   // Line comes straight off the bus
    .rd_data   (inst_data),
    .rd_hit    (rd_hit)
  );

  mem_bus_arbiter i_mem_bus_arbiter (
    .clock           (clock),
    .reset           (reset),
    .data_req        (data_req),
    .icache_req      (icache_req),
    .mem_reply       (mem_reply),
    .mem_req         (mem_req),
    .icache_response (icache_response),
    .icache_tag      (icache_tag),
    .data_response   (data_response),
    .data_tag        (data_tag),
    .data_rdata      (data_rdata)
  );

endmodule

/* source/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_e;

  typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

  // Fetch address split for the cache lookup
  typedef struct packed {
    logic [`XLEN-`ICACHE_TAG_BITS-`ICACHE_IDX_BITS-`LINE_OFFSET_BITS-1:0] unused;
    logic [`ICACHE_TAG_BITS-1:0]                                          tag;
    logic [`ICACHE_IDX_BITS-1:0]                                          idx;
    logic [`LINE_OFFSET_BITS-1:0]                                         offset;
  } icache_addr_fields_t;

  typedef union packed {
    logic [`XLEN-1:0]    raw;
    icache_addr_fields_t f;
  } icache_addr_u;

  // One request on the memory bus
  typedef struct packed {
    bus_command_e     command;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] data;   // Store data
  } mem_req_t;

  // What memory sends back each cycle
  typedef struct packed {
    mem_tag_t         response;   // Tag for the request in this cycle
    mem_tag_t         tag;        // Tag of the data returning now
    logic [`XLEN-1:0] data;
  } mem_reply_t;

  typedef struct packed {
    logic                        en;
    logic [`ICACHE_IDX_BITS-1:0] idx;
    logic [`ICACHE_TAG_BITS-1:0] tag;
  } icache_fill_t;

endpackage

/* source/icache_ctrl.sv */
`include "fetch_defines.svh"

module icache_ctrl (
  input  logic                        clock,
  input  logic                        reset,
  input  fetch_pkg::icache_addr_u     fetch_addr,
  input  logic                        rd_hit,
  input  fetch_pkg::mem_tag_t         icache_response,
  input  fetch_pkg::mem_tag_t         icache_tag,
  output logic [`ICACHE_IDX_BITS-1:0] rd_idx,
  output logic [`ICACHE_TAG_BITS-1:0] rd_tag,
  output fetch_pkg::icache_fill_t     fill,
  output fetch_pkg::mem_req_t         icache_req,
  output logic                        inst_valid
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,   // No miss in flight
    REQ,    // Refused, retrying the held line
    WAIT    // Accepted, line not back yet
  } state_e;

  state_e       state;
  icache_addr_u line_addr;
  icache_addr_u req_line;   // Line being loaded
  mem_tag_t     pend_tag;
  logic         miss;
  logic         accepted;
  logic         tag_back;

  assign rd_idx     = fetch_addr.f.idx;
  assign rd_tag     = fetch_addr.f.tag;
  assign miss       = !rd_hit;
  assign inst_valid = rd_hit;

  // Offset cleared for the line request
  always_comb begin
    line_addr          = fetch_addr;
    line_addr.f.offset = '0;
  end

  always_comb begin
    icache_req.command = BUS_NONE;
    icache_req.addr    = line_addr.raw;
    icache_req.data    = '0;   // Loads only
    case (state)
      IDLE: begin
        if (miss && !reset) begin   // Bus quiet while reset is held
          icache_req.command = BUS_LOAD;
        end
      end
      REQ: begin
        icache_req.command = BUS_LOAD;
        icache_req.addr    = req_line.raw;   // Same request until accepted
      end
      default: begin
        icache_req.command = BUS_NONE;
      end
    endcase
  end

  assign accepted = (icache_req.command == BUS_LOAD) && (icache_response != '0);

  // The arbiter only passes tags we own, still match the one we hold
  assign tag_back = (state == WAIT) && (icache_tag == pend_tag);

  always_comb begin
    fill.en  = tag_back;
    fill.idx = req_line.f.idx;
    fill.tag = req_line.f.tag;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (miss) begin
            state <= accepted ? WAIT : REQ;
          end
        end
        REQ: begin
          if (accepted) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if (tag_back) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == IDLE) && miss) begin
      req_line <= line_addr;   // Fill target even if fetch_addr moves on
    end
    if (accepted) begin
      pend_tag <= icache_response;
    end
  end

endmodule

/* source/icache_mem.sv */
`include "fetch_defines.svh"

module icache_mem (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`ICACHE_IDX_BITS-1:0] rd_idx,
  input  logic [`ICACHE_TAG_BITS-1:0] rd_tag,
  input  fetch_pkg::icache_fill_t     fill,
  input  logic [`XLEN-1:0]            fill_data,
  output logic [`XLEN-1:0]            rd_data,
  output logic                        rd_hit
);

  logic [`ICACHE_LINES-1:0]    line_valid;
  logic [`ICACHE_TAG_BITS-1:0] line_tag  [`ICACHE_LINES];
  logic [`XLEN-1:0]            line_data [`ICACHE_LINES];

  // Lookup is combinational
  assign rd_data = line_data[rd_idx];
  assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (fill.en) begin
      line_valid[fill.idx] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clock) begin
    if (fill.en) begin
      line_tag[fill.idx]  <= fill.tag;
      line_data[fill.idx] <= fill_data;
    end
  end

endmodule

/* source/mem_bus_arbiter.sv */
`include "fetch_defines.svh"

module mem_bus_arbiter (
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_pkg::mem_req_t   data_req,
  input  fetch_pkg::mem_req_t   icache_req,
  input  fetch_pkg::mem_reply_t mem_reply,
  output fetch_pkg::mem_req_t   mem_req,
  output fetch_pkg::mem_tag_t   icache_response,
  output fetch_pkg::mem_tag_t   icache_tag,
  output fetch_pkg::mem_tag_t   data_response,
  output fetch_pkg::mem_tag_t   data_tag,
  output logic [`XLEN-1:0]      data_rdata
);

  import fetch_pkg::*;

  logic [`NUM_MEM_TAGS-1:0] tag_live;     // Load outstanding under this tag
  logic [`NUM_MEM_TAGS-1:0] tag_icache;   // Owner, 1 for instruction side
  logic                     data_sel;
  logic                     load_accept;
  logic                     tag_owned;

  // Data port wins the bus
  assign data_sel = (data_req.command != BUS_NONE);
  assign mem_req  = data_sel ? data_req : icache_req;

  assign icache_response = data_sel ? '0 : mem_reply.response;
  assign data_response   = data_sel ? mem_reply.response : '0;

  assign load_accept = (mem_req.command == BUS_LOAD) && (mem_reply.response != '0);

  assign tag_owned = (mem_reply.tag != '0) && tag_live[mem_reply.tag];

  assign icache_tag = (tag_owned && tag_icache[mem_reply.tag]) ? mem_reply.tag : '0;
  assign data_tag   = (tag_owned && !tag_icache[mem_reply.tag]) ? mem_reply.tag : '0;
  assign data_rdata = (data_tag != '0) ? mem_reply.data : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_live <= '0;
    end else begin
      if (tag_owned) begin
        tag_live[mem_reply.tag] <= 1'b0;
      end
      // A tag reused in the same cycle stays live
      if (load_accept) begin
        tag_live[mem_reply.response] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_accept) begin
      tag_icache[mem_reply.response] <= !data_sel;
    end
  end

endmodule
